//--- bench/core_tb.sv
`timescale 1ns/1ps
/* core_tb
   runs a random program through mips_core and checks stores and stalls against an ISA model */
module core_tb;
   import core_pkg::*;

   localparam int prog_len     = 200;
   localparam int rst_cycles   = 4;
   localparam int clk_half     = 2;
   // 3 cycles per instruction plus slack, reset on top
   localparam int limit_cycles = rst_cycles + 3 * prog_len + 50;
   localparam logic [29:0] text_word = 30'(text_start >> 2);

   logic        clk = 1'b0;
   logic        rst_b;
   logic [29:0] inst_addr;
   logic [31:0] inst;
   logic [29:0] mem_addr;
   logic [31:0] mem_data_in;
   logic [3:0]  mem_write_en;
   logic [31:0] mem_data_out;

   logic [31:0] prog [0:prog_len-1];
   logic [31:0] dmem [0:63];
   logic [29:0] fetch_idx;
   logic [31:0] rng;

   // ISA model state and what it expects to see
   logic [31:0] ref_regs [0:31];
   logic [31:0] ref_mem [0:63];
   logic [29:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          exp_stalls;

   // observed on the DUT
   logic        running;
   logic        have_prev;
   logic [29:0] prev_addr;
   int          store_cnt;
   int          stall_cnt;

   mips_core uut (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out)
   );

   always #(clk_half) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // every word of the data array differs, whole index mixed in
   function automatic logic [31:0] fill_word(input int idx);
      return (32'(idx) * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
   endfunction

   function automatic logic [5:0] alu_funct(input logic [2:0] k);
      case (k)
         3'd0: return fn_addu;
         3'd1: return fn_subu;
         3'd2: return fn_and;
         3'd3: return fn_or;
         3'd4: return fn_xor;
         3'd5: return fn_nor;
         3'd6: return fn_slt;
         default: return fn_sltu;
      endcase
   endfunction

   function automatic logic [5:0] shift_funct(input logic [1:0] k);
      case (k)
         2'd0: return fn_sll;
         2'd1: return fn_srl;
         default: return fn_sra;
      endcase
   endfunction

   function automatic logic [5:0] imm_op(input logic [2:0] k);
      case (k)
         3'd0: return op_addiu;
         3'd1: return op_slti;
         3'd2: return op_andi;
         3'd3: return op_ori;
         default: return op_xori;
      endcase
   endfunction

   // signed word offset, -128 to +124 bytes
   function automatic logic [15:0] word_offset(input logic [5:0] k);
      return {{8{k[5]}}, k, 2'b00};
   endfunction

   task automatic flag_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      stop_run();
   endtask

   task automatic stop_run();
      $display("Done: errors found");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   task automatic gen_program();
      logic [31:0] r;
      logic [31:0] s;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      for (int i = 0; i < prog_len; i++) begin
         rng = xorshift(rng);
         r = rng;
         rng = xorshift(rng);
         s = rng;
         // only $0..$5, so neighbours keep reusing registers
         rs = 5'(r[31:26] % 6'd6);
         rt = 5'(r[25:20] % 6'd6);
         rd = 5'(r[19:14] % 6'd6);
         if (i < 5) begin
            // seed $1..$5 so nothing reads an unwritten register
            prog[i] = {op_addiu, 5'd0, 5'(i + 1), s[15:0]};
         end else if (r[3:0] < 4'd6) begin
            prog[i] = {op_special, rs, rt, rd, 5'd0, alu_funct(s[18:16])};
         end else if (r[3:0] < 4'd8) begin
            // constant shift, rs field stays zero
            prog[i] = {op_special, 5'd0, rt, rd, s[4:0], shift_funct(s[17:16])};
         end else if (r[3:0] < 4'd12) begin
            prog[i] = {imm_op(s[18:16]), rs, rt, s[15:0]};
         end else if (r[3:0] < 4'd14) begin
            prog[i] = {op_lw, rs, rt, word_offset(s[5:0])};
         end else begin
            prog[i] = {op_sw, rs, rt, word_offset(s[5:0])};
         end
      end
   endtask

   // in-order ISA model over its own registers and memory
   task automatic run_model();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sx;
      logic [31:0] zx;
      logic [31:0] addr;
      logic [31:0] res;
      logic [4:0]  dst;
      logic        wr;
      logic        reads_rs;
      logic        reads_rt;
      logic        prev_load;
      logic [4:0]  prev_dest;
      prev_load = 1'b0;
      prev_dest = 5'd0;
      exp_stalls = 0;
      for (int k = 0; k < 32; k++) begin
         ref_regs[k] = '0;
      end
      for (int i = 0; i < prog_len; i++) begin
         w = prog[i];
         a = ref_regs[w[25:21]];
         b = ref_regs[w[20:16]];
         sx = {{16{w[15]}}, w[15:0]};
         zx = {16'h0, w[15:0]};
         reads_rs = !(w[31:26] == op_special && w[5:0] inside {fn_sll, fn_srl, fn_sra});
         reads_rt = (w[31:26] == op_special) || (w[31:26] == op_sw);
         // load result needed by the very next instruction
         if (prev_load && prev_dest != 5'd0 &&
             ((reads_rs && prev_dest == w[25:21]) || (reads_rt && prev_dest == w[20:16]))) begin
            exp_stalls++;
         end
         prev_load = 1'b0;
         wr = 1'b1;
         dst = w[20:16];
         res = '0;
         case (w[31:26])
            op_special: begin
               dst = w[15:11];
               case (w[5:0])
                  fn_addu: res = a + b;
                  fn_subu: res = a - b;
                  fn_and:  res = a & b;
                  fn_or:   res = a | b;
                  fn_xor:  res = a ^ b;
                  fn_nor:  res = ~(a | b);
                  fn_slt:  res = {31'h0, $signed(a) < $signed(b)};
                  fn_sltu: res = {31'h0, a < b};
                  fn_sll:  res = b << w[10:6];
                  fn_srl:  res = b >> w[10:6];
                  fn_sra:  res = $unsigned($signed(b) >>> w[10:6]);
                  default: wr = 1'b0;
               endcase
            end
            op_addiu: res = a + sx;
            op_slti:  res = {31'h0, $signed(a) < $signed(sx)};
            op_andi:  res = a & zx;
            op_ori:   res = a | zx;
            op_xori:  res = a ^ zx;
            op_lw: begin
               addr = a + sx;
               res = ref_mem[addr[7:2]];
               prev_load = 1'b1;
               prev_dest = dst;
            end
            op_sw: begin
               addr = a + sx;
               ref_mem[addr[7:2]] = b;
               exp_addr.push_back(addr[31:2]);
               exp_data.push_back(b);
               wr = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         if (wr && dst != 5'd0) begin
            ref_regs[dst] = res;
         end
      end
   endtask

   // instruction memory, zero past the program is a no-op
   assign fetch_idx = inst_addr - text_word;
   assign inst = (fetch_idx < 30'(prog_len)) ? prog[fetch_idx[7:0]] : 32'h0;

   // data memory wraps every 64 words
   assign mem_data_out = dmem[mem_addr[5:0]];

   always @(posedge clk) begin
      if (!rst_b) begin
         for (int k = 0; k < 64; k++) begin
            dmem[k] <= fill_word(k);
         end
      end else if (mem_write_en != 4'h0) begin
         dmem[mem_addr[5:0]] <= mem_data_in;
      end
   end

   // mid-cycle sampling of the memory port and fetch address
   always @(negedge clk) begin
      if (running) begin
         if (mem_write_en != 4'h0) begin
            assert (mem_write_en == 4'hF)
               else flag_value("write_mask", 32'h0000_000f, 32'(mem_write_en));
            assert (store_cnt < exp_addr.size()) else begin
               $display("ERROR store_order: more stores reached memory than the program holds");
               stop_run();
            end
            assert (mem_addr == exp_addr[store_cnt])
               else flag_value("store_addr", 32'(exp_addr[store_cnt]), 32'(mem_addr));
            assert (mem_data_in == exp_data[store_cnt])
               else flag_value("store_data", exp_data[store_cnt], mem_data_in);
            store_cnt++;
         end
         // a held fetch address marks one stall cycle
         if (have_prev && inst_addr == prev_addr) begin
            stall_cnt++;
         end
         prev_addr = inst_addr;
         have_prev = 1'b1;
      end
   end

   initial begin
      rst_b = 1'b0;
      running = 1'b0;
      have_prev = 1'b0;
      prev_addr = '0;
      store_cnt = 0;
      stall_cnt = 0;
      rng = 32'h0f38_8629;
      gen_program();
      for (int k = 0; k < 64; k++) begin
         ref_mem[k] = fill_word(k);
      end
      run_model();
      repeat (rst_cycles) @(posedge clk);
      #1 rst_b = 1'b1;
      running = 1'b1;
      @(negedge clk);
      assert (inst_addr == text_word)
         else flag_value("reset_pc", 32'(text_word), 32'(inst_addr));
      assert (mem_write_en == 4'h0)
         else flag_value("reset_write_en", 32'h0, 32'(mem_write_en));
      // last instruction is past writeback once fetch is four words beyond the program
      while (inst_addr < text_word + 30'(prog_len + 4)) begin
         @(negedge clk);
      end
      @(negedge clk);
      #1;
      assert (store_cnt == exp_addr.size())
         else flag_value("store_count", 32'(exp_addr.size()), 32'(store_cnt));
      assert (stall_cnt == exp_stalls)
         else flag_value("load_use_stalls", 32'(exp_stalls), 32'(stall_cnt));
      $display("Done: no errors");
      $finish;
   end

   // watchdog
   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("ERROR timeout: the program did not drain within %0d cycles", limit_cycles);
      stop_run();
   end

endmodule

//--- build.f
rtl/core_pkg.sv
rtl/fetch_decode.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/mips_core.sv
bench/core_tb.sv

//--- rtl/core_pkg.sv
/* core_pkg
   widths, instruction encodings and pipeline register types shared by the core */
package core_pkg;

   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;

   // reset pc, start of the text segment
   localparam logic [xlen-1:0] text_start = 32'h0040_0000;

   // primary opcodes
   localparam logic [5:0] op_special = 6'h00;
   localparam logic [5:0] op_addiu   = 6'h09;
   localparam logic [5:0] op_slti    = 6'h0a;
   localparam logic [5:0] op_andi    = 6'h0c;
   localparam logic [5:0] op_ori     = 6'h0d;
   localparam logic [5:0] op_xori    = 6'h0e;
   localparam logic [5:0] op_lw      = 6'h23;
   localparam logic [5:0] op_sw      = 6'h2b;

   // funct field, only meaningful under op_special
   localparam logic [5:0] fn_sll  = 6'h00;
   localparam logic [5:0] fn_srl  = 6'h02;
   localparam logic [5:0] fn_sra  = 6'h03;
   localparam logic [5:0] fn_addu = 6'h21;
   localparam logic [5:0] fn_subu = 6'h23;
   localparam logic [5:0] fn_and  = 6'h24;
   localparam logic [5:0] fn_or   = 6'h25;
   localparam logic [5:0] fn_xor  = 6'h26;
   localparam logic [5:0] fn_nor  = 6'h27;
   localparam logic [5:0] fn_slt  = 6'h2a;
   localparam logic [5:0] fn_sltu = 6'h2b;

   typedef struct packed {
      logic [5:0]            op;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [reg_addr_w-1:0] rd;
      logic [4:0]            shamt;
      logic [5:0]            funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]            op;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [15:0]           imm;
   } i_fmt_t;

   // same 32 bits, read as either format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

   typedef enum logic [3:0] {
      alu_addu, alu_subu, alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
   } alu_op_t;

   // all zero is a bubble
   typedef struct packed {
      logic    reg_we;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src_imm;
      alu_op_t alu_op;
      logic    shift_imm;
      logic    spare;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [xlen-1:0]       rs_val;
      logic [xlen-1:0]       rt_val;
      logic [xlen-1:0]       imm;
      logic [4:0]            shamt;
      logic [reg_addr_w-1:0] dest;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [xlen-1:0]       result;
      logic [xlen-1:0]       store_val;
      logic [reg_addr_w-1:0] dest;
   } ex_mem_t;

   typedef struct packed {
      logic                  reg_we;
      logic [reg_addr_w-1:0] dest;
      logic [xlen-1:0]       value;
   } mem_wb_t;

   typedef enum logic [1:0] {
      fwd_none, fwd_mem, fwd_wb
   } fwd_sel_t;

endpackage

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
/* execute_stage
   operand forwarding, ALU and the execute-to-memory register */
module execute_stage (
   input  logic                      clk,
   input  logic                      rst_b,
   input  core_pkg::id_ex_t          id_ex,
   input  core_pkg::fwd_sel_t        fwd_rs,
   input  core_pkg::fwd_sel_t        fwd_rt,
   input  logic [core_pkg::xlen-1:0] mem_result,
   input  core_pkg::mem_wb_t         wb,
   output core_pkg::ex_mem_t         ex_mem
);
   import core_pkg::*;

   logic [xlen-1:0] op_a;
   logic [xlen-1:0] rt_fwd;
   logic [xlen-1:0] op_b;
   logic [4:0]      shift_cnt;
   logic [xlen-1:0] result;

   function automatic logic [xlen-1:0] pick(input fwd_sel_t sel,
                                            input logic [xlen-1:0] reg_val);
      case (sel)
         // never a load here, the stall keeps loads out of this path
         fwd_mem: return mem_result;
         fwd_wb:  return wb.value;
         default: return reg_val;
      endcase
   endfunction

   always_comb begin
      op_a = pick(fwd_rs, id_ex.rs_val);
      rt_fwd = pick(fwd_rt, id_ex.rt_val);
   end

   assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;
   // shifts move rt, count from shamt or low bits of rs
   assign shift_cnt = id_ex.ctrl.shift_imm ? id_ex.shamt : op_a[4:0];

   always_comb begin
      case (id_ex.ctrl.alu_op)
         alu_subu: result = op_a - op_b;
         alu_and:  result = op_a & op_b;
         alu_or:   result = op_a | op_b;
         alu_xor:  result = op_a ^ op_b;
         alu_nor:  result = ~(op_a | op_b);
         alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
         alu_sll:  result = op_b << shift_cnt;
         alu_srl:  result = op_b >> shift_cnt;
         alu_sra:  result = $unsigned($signed(op_b) >>> shift_cnt);
         // add, also load/store addressing
         default:  result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '0;
      end else begin
         ex_mem.ctrl <= id_ex.ctrl;
         ex_mem.result <= result;
         ex_mem.store_val <= rt_fwd;
         ex_mem.dest <= id_ex.dest;
      end
   end

endmodule

//--- rtl/fetch_decode.sv
`timescale 1ns/1ps
/* fetch_decode
   pc, fetch/decode register, field decode and control, loads the id_ex register */
module fetch_decode (
   input  logic                            clk,
   input  logic                            rst_b,
   input  logic                            stall,
   input  core_pkg::instr_t                inst,
   input  core_pkg::fwd_sel_t              fwd_rs,
   input  core_pkg::fwd_sel_t              fwd_rt,
   input  logic [core_pkg::xlen-1:0]       rs_val,
   input  logic [core_pkg::xlen-1:0]       rt_val,
   output logic [29:0]                     inst_addr,
   output logic [core_pkg::reg_addr_w-1:0] rs,
   output logic [core_pkg::reg_addr_w-1:0] rt,
   output logic                            uses_rt,
   output core_pkg::id_ex_t                id_ex,
   output core_pkg::fwd_sel_t              ex_fwd_rs,
   output core_pkg::fwd_sel_t              ex_fwd_rt
);
   import core_pkg::*;

   logic [xlen-1:0]       pc;
   instr_t                ir;
   ctrl_t                 ctrl;
   logic [xlen-1:0]       imm;
   logic [reg_addr_w-1:0] dest;

   // fetch side, both hold while a load-use stall is resolved
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= text_start;
         ir <= '0;
      end else if (!stall) begin
         pc <= pc + 'd4;
         ir <= inst;
      end
   end

   assign inst_addr = pc[xlen-1:2];
   assign rs = ir.r.rs;
   assign rt = ir.r.rt;

   always_comb begin
      ctrl = '0;
      uses_rt = 1'b0;
      // i-format defaults: rt is the target, immediate sign extended
      dest = ir.i.rt;
      imm = {{16{ir.i.imm[15]}}, ir.i.imm};
      if (ir.i.op inside {op_andi, op_ori, op_xori}) begin
         imm = {16'h0, ir.i.imm};
      end
      case (ir.r.op)
         op_special: begin
            dest = ir.r.rd;
            uses_rt = 1'b1;
            ctrl.reg_we = 1'b1;
            // constant shifts take their count from shamt
            ctrl.shift_imm = ir.r.funct inside {fn_sll, fn_srl, fn_sra};
            case (ir.r.funct)
               fn_sll:  ctrl.alu_op = alu_sll;
               fn_srl:  ctrl.alu_op = alu_srl;
               fn_sra:  ctrl.alu_op = alu_sra;
               fn_addu: ctrl.alu_op = alu_addu;
               fn_subu: ctrl.alu_op = alu_subu;
               fn_and:  ctrl.alu_op = alu_and;
               fn_or:   ctrl.alu_op = alu_or;
               fn_xor:  ctrl.alu_op = alu_xor;
               fn_nor:  ctrl.alu_op = alu_nor;
               fn_slt:  ctrl.alu_op = alu_slt;
               fn_sltu: ctrl.alu_op = alu_sltu;
               default: ctrl = '0;
            endcase
         end
         op_addiu, op_slti, op_andi, op_ori, op_xori: begin
            ctrl.reg_we = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            case (ir.i.op)
               op_slti: ctrl.alu_op = alu_slt;
               op_andi: ctrl.alu_op = alu_and;
               op_ori:  ctrl.alu_op = alu_or;
               op_xori: ctrl.alu_op = alu_xor;
               default: ctrl.alu_op = alu_addu;
            endcase
         end
         // address is base plus offset through the adder
         op_lw: begin
            ctrl.reg_we = 1'b1;
            ctrl.mem_read = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         op_sw: begin
            uses_rt = 1'b1;
            ctrl.mem_write = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         // unknown opcode runs as a no-op
         default: ctrl = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_ex <= '0;
         ex_fwd_rs <= fwd_none;
         ex_fwd_rt <= fwd_none;
      end else begin
         // bubble into execute while decode waits on a load
         id_ex.ctrl <= stall ? ctrl_t'('0) : ctrl;
         id_ex.rs <= ir.r.rs;
         id_ex.rt <= ir.r.rt;
         id_ex.rs_val <= rs_val;
         id_ex.rt_val <= rt_val;
         id_ex.imm <= imm;
         id_ex.shamt <= ir.r.shamt;
         id_ex.dest <= dest;
         ex_fwd_rs <= fwd_rs;
         ex_fwd_rt <= fwd_rt;
      end
   end

   // a stall needs a real load in execute, never the bubble a stall left behind
   a_stall_on_load: assert property (@(posedge clk) disable iff (!rst_b)
      stall |-> id_ex.ctrl.mem_read);

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
/* hazard_unit
   forwarding selects for the decode operands and load-use stall detection */
module hazard_unit (
   input  logic                            clk,
   input  logic                            rst_b,
   input  logic [core_pkg::reg_addr_w-1:0] rs,
   input  logic [core_pkg::reg_addr_w-1:0] rt,
   input  logic                            uses_rt,
   input  core_pkg::id_ex_t                id_ex,
   input  core_pkg::ex_mem_t               ex_mem,
   input  core_pkg::mem_wb_t               wb,
   output logic                            stall,
   output core_pkg::fwd_sel_t              fwd_rs,
   output core_pkg::fwd_sel_t              fwd_rt
);
   import core_pkg::*;

   logic ex_load;

   // selects are used one cycle later, when id_ex has moved to memory
   // and ex_mem to writeback, so the names follow where the value will be
   function automatic fwd_sel_t fwd_for(input logic [reg_addr_w-1:0] src);
      if (src == '0) begin
         return fwd_none;
      end
      // nearer producer first
      if (id_ex.ctrl.reg_we && id_ex.dest == src) begin
         return fwd_mem;
      end
      if (ex_mem.ctrl.reg_we && ex_mem.dest == src) begin
         return fwd_wb;
      end
      return fwd_none;
   endfunction

   always_comb begin
      fwd_rs = fwd_for(rs);
      fwd_rt = fwd_for(rt);
   end

   // load data only exists after memory, one cycle too late for execute
   assign ex_load = id_ex.ctrl.mem_read && (id_ex.dest != '0);
   assign stall = ex_load && ((id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

   a_stall_single: assert property (@(posedge clk) disable iff (!rst_b)
      stall |=> !stall);

   // a wb select must find its producer in writeback one cycle on
   a_fwd_wb_src: assert property (@(posedge clk) disable iff (!rst_b)
      fwd_rs == fwd_wb |=> wb.reg_we && wb.dest == $past(rs));

endmodule

//--- rtl/memory_writeback.sv
`timescale 1ns/1ps
/* memory_writeback
   data port drive, load capture and the memory-to-writeback register */
module memory_writeback (
   input  logic                      clk,
   input  logic                      rst_b,
   input  core_pkg::ex_mem_t         ex_mem,
   input  logic [core_pkg::xlen-1:0] mem_data_out,
   output logic [29:0]               mem_addr,
   output logic [core_pkg::xlen-1:0] mem_data_in,
   output logic [3:0]                mem_write_en,
   output core_pkg::mem_wb_t         wb
);

   // word address drops the low two bits of the sum
   assign mem_addr = ex_mem.result[31:2];
   assign mem_data_in = ex_mem.store_val;
   // word stores enable all four lanes or none
   assign mem_write_en = {4{ex_mem.ctrl.mem_write}};

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb <= '0;
      end else begin
         wb.reg_we <= ex_mem.ctrl.reg_we;
         wb.dest <= ex_mem.dest;
         // memory answers in the same cycle
         wb.value <= ex_mem.ctrl.mem_read ? mem_data_out : ex_mem.result;
      end
   end

   // full-word mask or no write at all
   a_store_mask: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en == 4'h0 || mem_write_en == 4'hF);

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps
/* mips_core
   five-stage in-order integer pipeline, memories outside the core */
module mips_core (
   input  logic                      clk,
   input  logic                      rst_b,
   output logic [29:0]               inst_addr,
   input  logic [core_pkg::xlen-1:0] inst,
   output logic [29:0]               mem_addr,
   output logic [core_pkg::xlen-1:0] mem_data_in,
   output logic [3:0]                mem_write_en,
   input  logic [core_pkg::xlen-1:0] mem_data_out
);
   import core_pkg::*;

   logic                  stall;
   logic [reg_addr_w-1:0] rs;
   logic [reg_addr_w-1:0] rt;
   logic                  uses_rt;
   logic [xlen-1:0]       rs_val;
   logic [xlen-1:0]       rt_val;
   // selects from decode, and their registered copies for execute
   fwd_sel_t              fwd_rs;
   fwd_sel_t              fwd_rt;
   fwd_sel_t              ex_fwd_rs;
   fwd_sel_t              ex_fwd_rt;
   id_ex_t                id_ex;
   ex_mem_t               ex_mem;
   mem_wb_t               wb;

   fetch_decode u_fetch_decode (
      .clk       (clk),
      .rst_b     (rst_b),
      .stall     (stall),
      .inst      (inst),
      .fwd_rs    (fwd_rs),
      .fwd_rt    (fwd_rt),
      .rs_val    (rs_val),
      .rt_val    (rt_val),
      .inst_addr (inst_addr),
      .rs        (rs),
      .rt        (rt),
      .uses_rt   (uses_rt),
      .id_ex     (id_ex),
      .ex_fwd_rs (ex_fwd_rs),
      .ex_fwd_rt (ex_fwd_rt)
   );

   regfile u_regfile (
      .clk    (clk),
      .rst_b  (rst_b),
      .rs     (rs),
      .rt     (rt),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .wb     (wb)
   );

   hazard_unit u_hazard_unit (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs      (rs),
      .rt      (rt),
      .uses_rt (uses_rt),
      .id_ex   (id_ex),
      .ex_mem  (ex_mem),
      .wb      (wb),
      .stall   (stall),
      .fwd_rs  (fwd_rs),
      .fwd_rt  (fwd_rt)
   );

   execute_stage u_execute_stage (
      .clk        (clk),
      .rst_b      (rst_b),
      .id_ex      (id_ex),
      .fwd_rs     (ex_fwd_rs),
      .fwd_rt     (ex_fwd_rt),
      .mem_result (ex_mem.result),
      .wb         (wb),
      .ex_mem     (ex_mem)
   );

   memory_writeback u_memory_writeback (
      .clk          (clk),
      .rst_b        (rst_b),
      .ex_mem       (ex_mem),
      .mem_data_out (mem_data_out),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .wb           (wb)
   );

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps
/* regfile
   31 general registers plus hardwired $0, two read ports, write-through from writeback */
module regfile (
   input  logic                            clk,
   input  logic                            rst_b,
   input  logic [core_pkg::reg_addr_w-1:0] rs,
   input  logic [core_pkg::reg_addr_w-1:0] rt,
   output logic [core_pkg::xlen-1:0]       rs_val,
   output logic [core_pkg::xlen-1:0]       rt_val,
   input  core_pkg::mem_wb_t               wb
);
   import core_pkg::*;

   // no storage behind $0
   logic [xlen-1:0] regs [1:31];
   logic            wr_en;

   function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
      if (addr == '0) begin
         return '0;
      end
      // same-cycle write wins over the stored value
      if (wr_en && wb.dest == addr) begin
         return wb.value;
      end
      return regs[addr];
   endfunction

   assign wr_en = wb.reg_we && (wb.dest != '0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[wb.dest] <= wb.value;
      end
   end

   always_comb begin
      rs_val = read_port(rs);
      rt_val = read_port(rt);
   end

   // $0 has no entry and must never be the write target
   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_b)
      wr_en |-> wb.dest != '0);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f build.f -o core_sim \
   && ./obj_dir/core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Done: no errors" sim.log && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }
